/* Makefile */
VERILATOR ?= verilator
TOP       ?= mem_bridge_tb
OBJ_DIR   ?= obj_dir
FILELIST  ?= filelist.f
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= STATUS: PASS

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* bench/mem_bridge_properties.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_bridge_properties (
    input logic clk,
    input logic rst,
    input logic inst_req,
    input logic inst_addr_ok,
    input logic data_req,
    input logic data_addr_ok,
    input logic halt,
    input logic exception_flag
);

    // failed assertions so far
    int unsigned fail_count = 0;

    a_inst_req_hold: assert property (@(posedge clk) disable iff (!rst)
        inst_req && !inst_addr_ok |=> inst_req)
        else begin
            $error("inst_req dropped before addr_ok");
            fail_count++;
        end

    a_data_req_hold: assert property (@(posedge clk) disable iff (!rst)
        data_req && !data_addr_ok |=> data_req)
        else begin
            $error("data_req dropped before addr_ok");
            fail_count++;
        end

    // one transfer in flight
    a_single_bus: assert property (@(posedge clk) disable iff (!rst)
        !(inst_req && data_req))
        else begin
            $error("req high on both buses");
            fail_count++;
        end

    // a pending request halts the core unless an exception masks it
    a_halt_masked: assert property (@(posedge clk) disable iff (!rst)
        (inst_req || data_req) |-> (halt == !exception_flag))
        else begin
            $error("halt does not follow exception_flag during a request");
            fail_count++;
        end

endmodule

`default_nettype wire

/* bench/mem_bridge_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mem_bridge_defs.svh"

module mem_bridge_tb import mem_bridge_pkg::*; ;

    localparam int MAX_LINES = 64;

    logic      clk;
    logic      rst;
    logic      exception_flag;
    cpu_port_t rom_port;
    cpu_port_t ram_port;
    logic [`MB_DATA_W-1:0] rom_read_data;
    logic [`MB_DATA_W-1:0] ram_read_data;
    logic      halt;
    logic      inst_req;
    inst_req_t inst_out;
    logic      inst_addr_ok;
    logic      inst_data_ok;
    logic [`MB_DATA_W-1:0] inst_rdata;
    logic      data_req;
    data_req_t data_out;
    logic      data_addr_ok;
    logic      data_data_ok;
    logic [`MB_DATA_W-1:0] data_rdata;

    logic [31:0] trace_mem [0:MAX_LINES*6-1];
    int          n_lines;
    int unsigned seq = 0;
    inst_req_t   inst_q[$];
    data_req_t   data_q[$];
    int unsigned inst_seq_q[$];
    int unsigned data_seq_q[$];

    // reference copy of the bridge's last-access state
    logic [`MB_ADDR_W-1:0] ref_rom_addr;
    logic [`MB_ADDR_W-1:0] ref_ram_addr;
    logic [`MB_DATA_W-1:0] ref_ram_data;
    logic                  ref_dirty;

    mem_bridge_top i_mem_bridge_top (
        .clk(clk), .rst(rst), .rom(rom_port), .ram(ram_port),
        .rom_read_data(rom_read_data), .ram_read_data(ram_read_data),
        .exception_flag(exception_flag), .halt(halt),
        .inst_req(inst_req), .inst_out(inst_out), .inst_addr_ok(inst_addr_ok),
        .inst_data_ok(inst_data_ok), .inst_rdata(inst_rdata),
        .data_req(data_req), .data_out(data_out), .data_addr_ok(data_addr_ok),
        .data_data_ok(data_data_ok), .data_rdata(data_rdata)
    );

    sram_like_model #(.FILL_KEY(32'h3c3c3c3c)) i_inst_mem (
        .clk(clk), .rst(rst), .req(inst_req), .wr(1'b0), .size(2'd2),
        .addr(inst_out.addr), .wdata(32'h0), .addr_ok(inst_addr_ok),
        .data_ok(inst_data_ok), .rdata(inst_rdata)
    );

    sram_like_model #(.FILL_KEY(32'h5a5a5a5a)) i_data_mem (
        .clk(clk), .rst(rst), .req(data_req), .wr(data_out.wr), .size(data_out.size),
        .addr(data_out.addr), .wdata(data_out.wdata), .addr_ok(data_addr_ok),
        .data_ok(data_data_ok), .rdata(data_rdata)
    );

    bind mem_bridge_top mem_bridge_properties i_mem_bridge_properties (
        .clk(clk), .rst(rst), .inst_req(inst_req), .inst_addr_ok(inst_addr_ok),
        .data_req(data_req), .data_addr_ok(data_addr_ok), .halt(halt),
        .exception_flag(exception_flag)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // bus monitors
    always @(posedge clk) begin
        if (rst && inst_req && inst_addr_ok) begin
            inst_q.push_back(inst_out);
            inst_seq_q.push_back(seq);
            seq++;
        end
        if (rst && data_req && data_addr_ok) begin
            data_q.push_back(data_out);
            data_seq_q.push_back(seq);
            seq++;
        end
    end

    task automatic abort_run(string why);
        $display("%s", why);
        $display("STATUS: FAIL");
        $fatal(1, "run aborted");
    endtask

    function automatic bit is_uncached(logic [`MB_ADDR_W-1:0] a);
        return (a[31:16] == `MB_UNCACHED_IO_TAG)
            || (a[31:28] >= `MB_UNCACHED_SEG_LO && a[31:28] <= `MB_UNCACHED_SEG_HI);
    endfunction

    function automatic logic [`MB_DATA_W-1:0] inst_fill(logic [`MB_ADDR_W-1:0] a);
        return {a[31:2], 2'b00} ^ 32'h3c3c3c3c;
    endfunction

    // encoder table: lane pattern to size and byte offset
    function automatic data_req_t expect_data_req(logic [3:0] wen, logic [31:0] addr,
                                                  logic [31:0] wdata);
        data_req_t r;
        r.wr    = |wen;
        r.wdata = wdata;
        r.size  = SIZE_WORD;
        r.addr  = addr;
        if (r.wr) begin
            r.addr = {addr[31:2], 2'b00};
            case (wen)
                4'h1, 4'h2, 4'h4, 4'h8: begin
                    r.size = SIZE_BYTE;
                    r.addr[1:0] = (wen == 4'h1) ? 2'd0 : (wen == 4'h2) ? 2'd1 :
                                  (wen == 4'h4) ? 2'd2 : 2'd3;
                end
                4'h3: r.size = SIZE_HALF;
                4'hc: begin
                    r.size = SIZE_HALF;
                    r.addr[1:0] = 2'd2;
                end
                4'hf: r.size = SIZE_WORD;
                default: begin
                    r.size = SIZE_BYTE;
                    r.addr = '0;
                end
            endcase
        end
        return r;
    endfunction

    task automatic check_word(string name, logic [31:0] exp, logic [31:0] got);
        if (exp !== got) begin
            abort_run($sformatf("Fail at %0t: %s expected %h got %h", $time, name, exp, got));
        end
    endtask

    task automatic check_data_req(data_req_t exp, data_req_t got);
        if (exp !== got) begin
            abort_run($sformatf("Fail at %0t: data_out expected %h got %h", $time, exp, got));
        end
    endtask

    task automatic check_inst_req(inst_req_t exp, inst_req_t got);
        if (exp !== got) begin
            abort_run($sformatf("Fail at %0t: inst_out expected %h got %h", $time, exp, got));
        end
    endtask

    task automatic check_access(string name, bit exp, bit got);
        if (exp !== got) begin
            abort_run($sformatf("Fail at %0t: %s expected %0b got %0b", $time, name, exp, got));
        end
    endtask

    // sampled 1 ns after the edge; returns in a run cycle
    task automatic wait_halt_cycle();
        bit seen_high;
        seen_high = 0;
        forever begin
            @(posedge clk);
            #1;
            if (halt) begin
                seen_high = 1;
            end else if (seen_high) begin
                break;
            end
        end
    endtask

    task automatic wait_exception_access();
        forever begin
            @(posedge clk);
            #1;
            if (halt) begin
                abort_run($sformatf("halt went high at %0t while exception_flag was set", $time));
            end
            if (data_data_ok) begin
                break;
            end
        end
        @(posedge clk);
        #2;
        exception_flag = 1'b0;
        rom_port.en    = 1'b0;
        ram_port.en    = 1'b0;
        wait_halt_cycle();
    endtask

    task automatic run_line(int i);
        logic [31:0] port;
        logic [3:0]  wen;
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [31:0] exp_data;
        bit          exp_acc;
        bit          rom_need;
        bit          ram_need;
        port     = trace_mem[i*6];
        wen      = trace_mem[i*6+1][3:0];
        addr     = trace_mem[i*6+2];
        wdata    = trace_mem[i*6+3];
        exp_data = trace_mem[i*6+4];
        exp_acc  = trace_mem[i*6+5][0];
        #1;
        rom_port       = '0;
        ram_port       = '0;
        rom_port.en    = (port == 0) || (port == 2);
        rom_port.addr  = addr;
        ram_port.en    = (port != 0);
        ram_port.wen   = wen;
        ram_port.wdata = wdata;
        ram_port.addr  = addr;
        exception_flag = (port == 3);
        rom_need = rom_port.en && (addr != ref_rom_addr);
        ram_need = ram_port.en && ((addr != ref_ram_addr) || is_uncached(addr)
                   || ((|wen) ? (wdata != ref_ram_data) : ref_dirty));
        if (port == 3) begin
            wait_exception_access();
        end else begin
            wait_halt_cycle();
        end
        if (inst_q.size() > 1 || data_q.size() > 1) begin
            abort_run($sformatf("more than one bus transfer for trace line %0d", i));
        end
        if (rom_port.en || port == 0 || port == 2) begin
            check_access("rom_ref_access", exp_acc, rom_need);
        end
        if (port != 0) begin
            check_access("ram_ref_access", exp_acc, ram_need);
        end
        check_access("inst_bus_access", rom_need, inst_q.size() != 0);
        check_access("data_bus_access", ram_need, data_q.size() != 0);
        if (rom_need) begin
            check_inst_req(inst_req_t'(addr), inst_q[0]);
            ref_rom_addr = addr;
        end
        if (ram_need) begin
            check_data_req(expect_data_req(wen, addr, wdata), data_q[0]);
            ref_ram_addr = addr;
            ref_ram_data = (|wen) ? wdata : exp_data;
            ref_dirty    = (|wen) && (wen != 4'hf);
        end
        if (rom_need && ram_need && data_seq_q[0] > inst_seq_q[0]) begin
            abort_run($sformatf("instruction transfer came before data on line %0d", i));
        end
        if (port == 0) begin
            check_word("rom_read_data", exp_data, rom_read_data);
        end else begin
            check_word("ram_read_data", exp_data, ram_read_data);
        end
        if (port == 2) begin
            check_word("rom_read_data", inst_fill(addr), rom_read_data);
        end
        inst_q.delete();
        data_q.delete();
        inst_seq_q.delete();
        data_seq_q.delete();
    endtask

    initial begin
        wait (n_lines > 0);
        repeat (n_lines * 64 + 16) @(posedge clk);
        abort_run("watchdog expired: the bridge stopped making progress");
    end

    initial begin
        void'($urandom(12));
        rst            = 1'b0;
        exception_flag = 1'b0;
        rom_port       = '0;
        ram_port       = '0;
        ref_rom_addr   = '0;
        ref_ram_addr   = '0;
        ref_ram_data   = '0;
        ref_dirty      = 1'b0;
        for (int k = 0; k < MAX_LINES*6; k++) begin
            trace_mem[k] = 32'hffffffff;
        end
        $readmemh("bench/mem_bridge_trace.txt", trace_mem);
        while (n_lines < MAX_LINES && trace_mem[n_lines*6] != 32'hffffffff) begin
            n_lines++;
        end
        if (n_lines == 0) begin
            abort_run("trace file is empty or missing");
        end
        repeat (4) @(posedge clk);
        #2;
        rst = 1'b1;
        wait_halt_cycle();
        for (int i = 0; i < n_lines; i++) begin
            run_line(i);
        end
        if (i_mem_bridge_top.i_mem_bridge_properties.fail_count == 0) begin
            $display("STATUS: PASS");
            $finish;
        end else begin
            abort_run("a bus or halt assertion failed during the run");
        end
    end

endmodule

`default_nettype wire

/* bench/mem_bridge_trace.txt */
// port(0 rom,1 ram,2 both,3 ram+exception) wen addr wdata exp_rdata exp_access
0 0 00000400 00000000 3c3c383c 1
0 0 00000400 00000000 3c3c383c 0
0 0 00000404 00000000 3c3c3838 1
1 f 00000100 11223344 11223344 1
1 0 00000100 00000000 11223344 0
1 f 00000100 11223344 11223344 0
1 1 00000100 000000aa 000000aa 1
1 0 00000100 00000000 112233aa 1
1 2 00000100 0000bb00 0000bb00 1
1 0 00000100 00000000 1122bbaa 1
1 4 00000100 00cc0000 00cc0000 1
1 0 00000100 00000000 11ccbbaa 1
1 8 00000100 dd000000 dd000000 1
1 0 00000100 00000000 ddccbbaa 1
1 3 00000100 00005566 00005566 1
1 0 00000100 00000000 ddcc5566 1
1 c 00000100 77880000 77880000 1
1 0 00000100 00000000 77885566 1
1 0 ffff0010 00000000 a5a55a4a 1
1 0 ffff0010 00000000 a5a55a4a 1
1 0 a0000020 00000000 fa5a5a7a 1
1 0 a0000020 00000000 fa5a5a7a 1
1 0 b0000040 00000000 ea5a5a1a 1
1 0 b0000040 00000000 ea5a5a1a 1
2 0 00000200 00000000 5a5a585a 1
3 0 00000300 00000000 5a5a595a 1

/* bench/sram_like_model.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mem_bridge_defs.svh"

module sram_like_model #(
    parameter logic [`MB_DATA_W-1:0] FILL_KEY = '0
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  req,
    input  logic                  wr,
    input  logic [1:0]            size,
    input  logic [`MB_ADDR_W-1:0] addr,
    input  logic [`MB_DATA_W-1:0] wdata,
    output logic                  addr_ok,
    output logic                  data_ok,
    output logic [`MB_DATA_W-1:0] rdata
);

    logic [`MB_DATA_W-1:0] mem [logic [`MB_ADDR_W-3:0]];
    logic [`MB_ADDR_W-1:0] held_addr;
    logic                  busy;
    int unsigned           gap;
    int unsigned           lat;

    // unwritten words come from the whole address
    function automatic logic [`MB_DATA_W-1:0] read_word(logic [`MB_ADDR_W-1:0] a);
        if (mem.exists(a[`MB_ADDR_W-1:2])) begin
            return mem[a[`MB_ADDR_W-1:2]];
        end
        return {a[`MB_ADDR_W-1:2], 2'b00} ^ FILL_KEY;
    endfunction

    function automatic logic [3:0] lane_mask(logic [1:0] sz, logic [1:0] off);
        if (sz == 2'd0) begin
            return 4'b0001 << off;
        end else if (sz == 2'd1) begin
            return off[1] ? 4'b1100 : 4'b0011;
        end
        return 4'b1111;
    endfunction

    task automatic write_lanes(logic [`MB_ADDR_W-1:0] a, logic [1:0] sz,
                               logic [`MB_DATA_W-1:0] d);
        logic [`MB_DATA_W-1:0] word;
        logic [3:0]            mask;
        word = read_word(a);
        mask = lane_mask(sz, a[1:0]);
        for (int i = 0; i < 4; i++) begin
            if (mask[i]) begin
                word[8*i +: 8] = d[8*i +: 8];
            end
        end
        mem[a[`MB_ADDR_W-1:2]] = word;
    endtask

    always @(posedge clk) begin
        if (!rst) begin
            addr_ok <= 1'b0;
            data_ok <= 1'b0;
            rdata   <= '0;
            busy    <= 1'b0;
            gap     <= 0;
        end else begin
            addr_ok <= 1'b0;
            data_ok <= 1'b0;
            if (busy) begin
                if (lat == 0) begin
                    data_ok <= 1'b1;
                    rdata   <= read_word(held_addr);
                    busy    <= 1'b0;
                end else begin
                    lat <= lat - 1;
                end
            end else if (req && addr_ok) begin
                held_addr <= addr;
                if (wr) begin
                    write_lanes(addr, size, wdata);
                end
                busy <= 1'b1;
                lat  <= $urandom % 3;
            end else if (req) begin
                if (gap == 0) begin
                    addr_ok <= 1'b1;
                end else begin
                    gap <= gap - 1;
                end
            end else begin
                gap <= $urandom % 3;
            end
        end
    end

endmodule

`default_nettype wire

/* filelist.f */
+incdir+include
hdl/mem_bridge_pkg.sv
hdl/byte_lane_encoder.sv
hdl/access_filter.sv
hdl/sram_channel.sv
hdl/access_arbiter.sv
hdl/mem_bridge_top.sv
bench/sram_like_model.sv
bench/mem_bridge_properties.sv
bench/mem_bridge_tb.sv

/* hdl/access_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

module access_arbiter import mem_bridge_pkg::*; (
    input  logic clk,
    input  logic rst,
    input  logic need_ram,
    input  logic need_rom,
    input  logic ram_done,
    input  logic rom_done,
    input  logic exception_flag,
    output logic ram_active,
    output logic rom_active,
    output logic halt
);

    arb_state_t state;
    arb_state_t next_state;

    always_ff @(posedge clk) begin
        if (!rst) begin
            state <= ST_RUN;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            ST_RUN: begin
                next_state = ST_WAIT;
            end
            // ram first, rom second
            ST_WAIT: begin
                if (need_ram) begin
                    next_state = ST_RAM;
                end else if (need_rom) begin
                    next_state = ST_ROM;
                end else begin
                    next_state = ST_RUN;
                end
            end
            ST_RAM: begin
                if (ram_done) begin
                    next_state = need_rom ? ST_ROM : ST_RUN;
                end
            end
            ST_ROM: begin
                if (rom_done) begin
                    next_state = ST_RUN;
                end
            end
            default: begin
                next_state = ST_RUN;
            end
        endcase
    end

    assign ram_active = (state == ST_RAM);
    assign rom_active = (state == ST_ROM);

    // an exception lets the core flush regardless of bus state
    assign halt = !exception_flag && (state != ST_RUN);

endmodule

`default_nettype wire

/* hdl/access_filter.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mem_bridge_defs.svh"

module access_filter import mem_bridge_pkg::*; (
    input  logic                  clk,
    input  logic                  rst,
    input  cpu_port_t             rom,
    input  cpu_port_t             ram,
    input  data_req_t             data_req,
    input  logic [`MB_DATA_W-1:0] inst_rdata,
    input  logic [`MB_DATA_W-1:0] data_rdata,
    input  logic                  inst_accepted,
    input  logic                  data_accepted,
    input  logic                  inst_done,
    input  logic                  data_done,
    output logic                  need_rom,
    output logic                  need_ram,
    output logic [`MB_DATA_W-1:0] rom_read_data,
    output logic [`MB_DATA_W-1:0] ram_read_data
);

    logic [`MB_ADDR_W-1:0] last_rom_addr;
    logic [`MB_ADDR_W-1:0] last_ram_addr;
    logic [`MB_DATA_W-1:0] last_rom_data;
    logic [`MB_DATA_W-1:0] last_ram_data;
    logic                  ram_dirty;
    logic [15:0]           upper_half;
    logic [3:0]            top_nibble;
    logic                  ram_uncached;
    logic                  ram_data_stale;

    assign upper_half = ram.addr[`MB_ADDR_W-1 -: 16];
    assign top_nibble = ram.addr[`MB_ADDR_W-1 -: 4];

    assign ram_uncached = (upper_half == `MB_UNCACHED_IO_TAG)
                       || (top_nibble >= `MB_UNCACHED_SEG_LO
                           && top_nibble <= `MB_UNCACHED_SEG_HI);

    // writes compare payload, reads only care about a pending partial write
    assign ram_data_stale = (|ram.wen) ? (ram.wdata != last_ram_data) : ram_dirty;

    assign need_rom = rom.en && (rom.addr != last_rom_addr);
    assign need_ram = ram.en && ((ram.addr != last_ram_addr)
                              || ram_uncached
                              || ram_data_stale);

    assign rom_read_data = last_rom_data;
    assign ram_read_data = last_ram_data;

    // address recorded once the bus takes the request
    always_ff @(posedge clk) begin
        if (!rst) begin
            last_rom_addr <= '0;
            last_ram_addr <= '0;
        end else begin
            if (inst_accepted) begin
                last_rom_addr <= rom.addr;
            end
            if (data_accepted) begin
                last_ram_addr <= ram.addr;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            last_rom_data <= '0;
            last_ram_data <= '0;
            ram_dirty     <= 1'b0;
        end else begin
            if (data_done) begin
                if (data_req.wr) begin
                    last_ram_data <= data_req.wdata;
                    ram_dirty     <= (data_req.size != SIZE_WORD);
                end else begin
                    last_ram_data <= data_rdata;
                    ram_dirty     <= 1'b0;
                end
            end
            if (inst_done) begin
                last_rom_data <= inst_rdata;
            end
        end
    end

endmodule

`default_nettype wire

/* hdl/byte_lane_encoder.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mem_bridge_defs.svh"

module byte_lane_encoder import mem_bridge_pkg::*; (
    input  cpu_port_t ram,
    output data_req_t req
);

    always_comb begin
        req.wr    = |ram.wen;
        req.wdata = ram.wdata;
        req.size  = SIZE_WORD;
        req.addr  = ram.addr;
        if (req.wr) begin
            case (ram.wen)
                4'b0001: begin
                    req.size = SIZE_BYTE;
                    req.addr = {ram.addr[`MB_ADDR_W-1:2], 2'b00};
                end
                4'b0010: begin
                    req.size = SIZE_BYTE;
                    req.addr = {ram.addr[`MB_ADDR_W-1:2], 2'b01};
                end
                4'b0100: begin
                    req.size = SIZE_BYTE;
                    req.addr = {ram.addr[`MB_ADDR_W-1:2], 2'b10};
                end
                4'b1000: begin
                    req.size = SIZE_BYTE;
                    req.addr = {ram.addr[`MB_ADDR_W-1:2], 2'b11};
                end
                4'b0011: begin
                    req.size = SIZE_HALF;
                    req.addr = {ram.addr[`MB_ADDR_W-1:2], 2'b00};
                end
                4'b1100: begin
                    req.size = SIZE_HALF;
                    req.addr = {ram.addr[`MB_ADDR_W-1:2], 2'b10};
                end
                4'b1111: begin
                    req.size = SIZE_WORD;
                    req.addr = {ram.addr[`MB_ADDR_W-1:2], 2'b00};
                end
                // unsupported lane mix
                default: begin
                    req.size = SIZE_BYTE;
                    req.addr = '0;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* hdl/mem_bridge_pkg.sv */
`default_nettype none

`include "mem_bridge_defs.svh"

package mem_bridge_pkg;

    // one core port, held steady while halt is high
    typedef struct packed {
        logic                 en;
        logic [`MB_WEN_W-1:0]  wen;
        logic [`MB_DATA_W-1:0] wdata;
        logic [`MB_ADDR_W-1:0] addr;
    } cpu_port_t;

    typedef enum logic [1:0] {
        SIZE_BYTE = 2'd0,
        SIZE_HALF = 2'd1,
        SIZE_WORD = 2'd2
    } bus_size_t;

    // instruction bus only ever reads whole words
    typedef struct packed {
        logic [`MB_ADDR_W-1:0] addr;
    } inst_req_t;

    typedef struct packed {
        logic                  wr;
        bus_size_t             size;
        logic [`MB_ADDR_W-1:0] addr;
        logic [`MB_DATA_W-1:0] wdata;
    } data_req_t;

    typedef enum logic [1:0] {
        ST_RUN  = 2'd0,
        ST_WAIT = 2'd1,
        ST_RAM  = 2'd2,
        ST_ROM  = 2'd3
    } arb_state_t;

endpackage

`default_nettype wire

/* hdl/mem_bridge_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mem_bridge_defs.svh"

module mem_bridge_top import mem_bridge_pkg::*; (
    input  logic                  clk,
    input  logic                  rst,
    input  cpu_port_t             rom,
    input  cpu_port_t             ram,
    output logic [`MB_DATA_W-1:0] rom_read_data,
    output logic [`MB_DATA_W-1:0] ram_read_data,
    input  logic                  exception_flag,
    output logic                  halt,
    output logic                  inst_req,
    output inst_req_t             inst_out,
    input  logic                  inst_addr_ok,
    input  logic                  inst_data_ok,
    input  logic [`MB_DATA_W-1:0] inst_rdata,
    output logic                  data_req,
    output data_req_t             data_out,
    input  logic                  data_addr_ok,
    input  logic                  data_data_ok,
    input  logic [`MB_DATA_W-1:0] data_rdata
);

    data_req_t enc_req;
    inst_req_t inst_payload;
    logic      need_rom;
    logic      need_ram;
    logic      ram_active;
    logic      rom_active;
    logic      inst_accepted;
    logic      data_accepted;
    logic      inst_done;
    logic      data_done;

    // fetch is always a word read, so only the address travels
    assign inst_payload.addr = rom.addr;

    byte_lane_encoder i_byte_lane_encoder (
        .ram (ram),
        .req (enc_req)
    );

    access_filter i_access_filter (
        .clk           (clk),
        .rst           (rst),
        .rom           (rom),
        .ram           (ram),
        .data_req      (enc_req),
        .inst_rdata    (inst_rdata),
        .data_rdata    (data_rdata),
        .inst_accepted (inst_accepted),
        .data_accepted (data_accepted),
        .inst_done     (inst_done),
        .data_done     (data_done),
        .need_rom      (need_rom),
        .need_ram      (need_ram),
        .rom_read_data (rom_read_data),
        .ram_read_data (ram_read_data)
    );

    access_arbiter i_access_arbiter (
        .clk            (clk),
        .rst            (rst),
        .need_ram       (need_ram),
        .need_rom       (need_rom),
        .ram_done       (data_done),
        .rom_done       (inst_done),
        .exception_flag (exception_flag),
        .ram_active     (ram_active),
        .rom_active     (rom_active),
        .halt           (halt)
    );

    sram_channel #(.req_t(inst_req_t)) i_inst_channel (
        .clk      (clk),
        .rst      (rst),
        .active   (rom_active),
        .payload  (inst_payload),
        .req      (inst_req),
        .req_out  (inst_out),
        .addr_ok  (inst_addr_ok),
        .data_ok  (inst_data_ok),
        .accepted (inst_accepted),
        .done     (inst_done)
    );

    sram_channel #(.req_t(data_req_t)) i_data_channel (
        .clk      (clk),
        .rst      (rst),
        .active   (ram_active),
        .payload  (enc_req),
        .req      (data_req),
        .req_out  (data_out),
        .addr_ok  (data_addr_ok),
        .data_ok  (data_data_ok),
        .accepted (data_accepted),
        .done     (data_done)
    );

endmodule

`default_nettype wire

/* hdl/sram_channel.sv */
`timescale 1ns/1ps
`default_nettype none

module sram_channel #(
    parameter type req_t = logic
) (
    input  logic clk,
    input  logic rst,
    input  logic active,
    input  req_t payload,
    output logic req,
    output req_t req_out,
    input  logic addr_ok,
    input  logic data_ok,
    output logic accepted,
    output logic done
);

    // set after the address handshake, so req fires once per visit
    logic issued;

    // request fields track the core port directly
    assign req_out = payload;

    assign accepted = req && addr_ok;
    assign done     = data_ok;

    always_ff @(posedge clk) begin
        if (!rst) begin
            req    <= 1'b0;
            issued <= 1'b0;
        end else if (!active) begin
            req    <= 1'b0;
            issued <= 1'b0;
        end else if (accepted) begin
            req    <= 1'b0;
            issued <= 1'b1;
        end else if (!issued) begin
            req <= 1'b1;
        end
    end

endmodule

`default_nettype wire

/* include/mem_bridge_defs.svh */
`ifndef MEM_BRIDGE_DEFS_SVH
`define MEM_BRIDGE_DEFS_SVH

// core and bus widths
`define MB_ADDR_W 32
`define MB_DATA_W 32
`define MB_WEN_W  4

// uncached windows
// top nibble in [seg_lo, seg_hi], or upper half-word equal to io_tag
`define MB_UNCACHED_SEG_LO 4'ha
`define MB_UNCACHED_SEG_HI 4'hb
`define MB_UNCACHED_IO_TAG 16'hffff

`endif
